//--- logic/spi_pkg.sv
/* Widths, word types, APB register map, register bit positions and
   the engine state encoding shared across the SPI master. */
package spi_pkg;

    ////////////////////////////////////////
    // Widths and types.
    ////////////////////////////////////////
    localparam int DATA_W = 8;               // Bits in one SPI word.

    typedef logic [DATA_W-1:0] word_t;       // Transmit or receive word.
    typedef logic [2:0]        presc_t;      // Setting p gives 2^(p+1) cycles per half-period.
    typedef logic [1:0]        spi_mode_t;   // Bit 1 is CPOL, bit 0 is CPHA.
    typedef logic [3:0]        apb_addr_t;   // APB byte address.
    typedef logic [31:0]       apb_data_t;   // APB data bus.

    ////////////////////////////////////////
    // APB register map.
    ////////////////////////////////////////
    localparam apb_addr_t ADDR_CTRL   = 4'h0;
    localparam apb_addr_t ADDR_TXDATA = 4'h4;
    localparam apb_addr_t ADDR_RXDATA = 4'h8;
    localparam apb_addr_t ADDR_STATUS = 4'hC;

    // CTRL fields.
    localparam int CTRL_MODE_LSB  = 0;       // Mode sits in bits 1:0.
    localparam int CTRL_LSBF_BIT  = 2;       // Set for LSB-first order.
    localparam int CTRL_PRESC_LSB = 3;       // Prescaler sits in bits 5:3.

    // STATUS fields.
    localparam int STAT_TX_EMPTY  = 0;
    localparam int STAT_BUSY      = 1;
    localparam int STAT_CHAR_RX   = 2;
    localparam int STAT_SEND_ERR  = 3;       // Write 1 here to clear the flag.

    // Engine FSM states.
    typedef enum logic {
        ENG_IDLE,
        ENG_BUSY
    } engine_state_e;

endpackage

//--- logic/spi_ctrl_if.sv
`timescale 1ns/1ns
/* Control bus between the APB register block and the SPI engine. */
interface spi_ctrl_if;
    import spi_pkg::*;

    // Driven by the register block.
    word_t     tx_word;      // Word waiting in the transmit buffer.
    logic      tx_full;      // High while tx_word has not been taken yet.
    spi_mode_t mode;         // CPOL and CPHA from CTRL.
    logic      lsbfirst;     // Bit order from CTRL.
    presc_t    presc;        // Prescaler select from CTRL.

    // Driven by the engine.
    logic      tx_take;      // One-cycle pulse as the engine copies tx_word.
    word_t     rx_word;      // Received word, valid while rx_done is high.
    logic      rx_done;      // One-cycle pulse at the end of a word.
    logic      busy;         // Engine is shifting a word.

    modport regs (
        output tx_word, tx_full, mode, lsbfirst, presc,
        input  tx_take, rx_word, rx_done, busy
    );

    // The prescaler goes to the baud generator, not to the engine.
    modport engine (
        input  tx_word, tx_full, mode, lsbfirst,
        output tx_take, rx_word, rx_done, busy
    );

endinterface

//--- logic/spi_apb_regs.sv
`timescale 1ns/1ns
/* APB slave with CTRL, the one-word transmit buffer, the receive
   buffer and the status flags. */
module spi_apb_regs (
    input  logic               wr,
    input  logic               rst,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  spi_pkg::apb_addr_t paddr,
    input  spi_pkg::apb_data_t pwdata,
    output spi_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr,
    spi_ctrl_if.regs           ctrl
);
    import spi_pkg::*;

    logic  access;           // APB access cycle.
    logic  addr_ok;          // Offset is one of the four registers.
    logic  wr_acc;           // Write that takes effect this cycle.
    logic  rd_acc;           // Read that takes effect this cycle.
    logic  tx_accept;        // TXDATA write into an empty buffer.
    logic  tx_reject;        // TXDATA write into a full buffer.
    logic  err_clear;
    logic  rx_read;
    logic  char_received;
    logic  send_error;
    word_t rx_buf;

    ////////////////////////////////////////
    // Access decode.
    ////////////////////////////////////////
    assign access  = psel && penable;
    assign addr_ok = paddr inside {ADDR_CTRL, ADDR_TXDATA, ADDR_RXDATA, ADDR_STATUS};
    assign pready  = 1'b1;   // No wait states.
    // Unmapped offsets and writes to the read-only RXDATA are errors.
    assign pslverr = access && (!addr_ok || (pwrite && paddr == ADDR_RXDATA));

    assign wr_acc    = access && pwrite && !pslverr;
    assign rd_acc    = access && !pwrite && !pslverr;
    assign tx_accept = wr_acc && (paddr == ADDR_TXDATA) && !ctrl.tx_full;
    assign tx_reject = wr_acc && (paddr == ADDR_TXDATA) && ctrl.tx_full;
    assign err_clear = wr_acc && (paddr == ADDR_STATUS) && pwdata[STAT_SEND_ERR];
    assign rx_read   = rd_acc && (paddr == ADDR_RXDATA);

    // Read mux.
    always_comb begin
        prdata = '0;
        case (paddr)
            ADDR_CTRL: begin
                prdata[CTRL_MODE_LSB +: $bits(spi_mode_t)] = ctrl.mode;
                prdata[CTRL_LSBF_BIT]                      = ctrl.lsbfirst;
                prdata[CTRL_PRESC_LSB +: $bits(presc_t)]   = ctrl.presc;
            end
            ADDR_RXDATA: prdata[DATA_W-1:0] = rx_buf;
            ADDR_STATUS: begin
                prdata[STAT_TX_EMPTY] = !ctrl.tx_full;
                prdata[STAT_BUSY]     = ctrl.busy;
                prdata[STAT_CHAR_RX]  = char_received;
                prdata[STAT_SEND_ERR] = send_error;
            end
            default: prdata = '0;  // TXDATA reads back as zero.
        endcase
    end

    ////////////////////////////////////////
    // Configuration and flags.
    ////////////////////////////////////////
    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            ctrl.mode     <= '0;
            ctrl.lsbfirst <= 1'b0;
            ctrl.presc    <= '0;
            ctrl.tx_full  <= 1'b0;
            char_received <= 1'b0;
            send_error    <= 1'b0;
        end else begin
            if (wr_acc && paddr == ADDR_CTRL) begin
                ctrl.mode     <= pwdata[CTRL_MODE_LSB +: $bits(spi_mode_t)];
                ctrl.lsbfirst <= pwdata[CTRL_LSBF_BIT];
                ctrl.presc    <= pwdata[CTRL_PRESC_LSB +: $bits(presc_t)];
            end
            // The engine only takes a full buffer, so these never collide.
            if (tx_accept) begin
                ctrl.tx_full <= 1'b1;
            end else if (ctrl.tx_take) begin
                ctrl.tx_full <= 1'b0;
            end
            if (tx_reject) begin
                send_error <= 1'b1;            // Sticky until the host clears it.
            end else if (err_clear) begin
                send_error <= 1'b0;
            end
            // A new word wins over a read in the same cycle.
            if (ctrl.rx_done) begin
                char_received <= 1'b1;
            end else if (rx_read) begin
                char_received <= 1'b0;
            end
        end
    end

    // Data buffers.
    always_ff @(posedge wr) begin
        if (tx_accept) begin
            ctrl.tx_word <= pwdata[DATA_W-1:0];
        end
        if (ctrl.rx_done) begin
            rx_buf <= ctrl.rx_word;            // Older word is simply overwritten.
        end
    end

    // An accepted word must never be reported as a send error.
    a_no_err_on_accept: assert property (@(posedge wr) disable iff (rst)
        tx_accept |=> !$rose(send_error));

endmodule

//--- logic/spi_baud_gen.sv
`timescale 1ns/1ns
/* Prescaler counter that marks the end of each sck half-period. */
module spi_baud_gen #(
    parameter int PRESC_W = 8
) (
    input  logic            wr,
    input  logic            rst,
    input  logic            run,
    input  spi_pkg::presc_t presc,
    output logic            tick
);
    import spi_pkg::*;

    presc_t             presc_q;   // Setting frozen for the whole word.
    logic [PRESC_W-1:0] cnt;
    logic [PRESC_W-1:0] term;      // Terminal count, 2^(p+1) - 1.

    assign term = PRESC_W'(8'hFF >> (3'd7 - presc_q));
    assign tick = (cnt == term);

    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            cnt     <= '0;
            presc_q <= '0;
        end else if (!run) begin
            cnt     <= '0;
            presc_q <= presc;      // Last sample lands in the take cycle.
        end else if (tick) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Run only drops on a tick edge, where the counter wraps to zero.
    a_no_tick_idle: assert property (@(posedge wr) disable iff (rst)
        !run |-> !tick);

endmodule

//--- logic/spi_engine.sv
`timescale 1ns/1ns
/* SPI transfer FSM with the shift registers, slave select and pin
   drive for all four modes in either bit order. */
module spi_engine (
    input  logic       wr,
    input  logic       rst,
    spi_ctrl_if.engine ctrl,
    output logic       run,
    input  logic       tick,
    output logic       sck,
    output logic       mosi,
    input  logic       miso,
    output logic       ss
);
    import spi_pkg::*;

    localparam int              HALF_N  = 2 * DATA_W;       // Half-periods per word.
    localparam int              HP_W    = $clog2(HALF_N);
    localparam logic [HP_W-1:0] HP_LAST = HP_W'(HALF_N - 1);

    engine_state_e   state;
    logic [HP_W-1:0] hp;           // Half-period index within the word.
    spi_mode_t       mode_q;       // Mode latched for the current word.
    logic            lsb_q;        // Bit order latched for the current word.
    logic            rx_done_q;
    word_t           tx_sh;        // Outgoing bits, the current one at the exit end.
    word_t           rx_sh;        // Incoming bits.
    logic            tx_bit;
    logic            sample_now;
    logic            shift_now;
    logic            word_end;

    ////////////////////////////////////////
    // Handshake and pin drive.
    ////////////////////////////////////////
    assign ctrl.tx_take = (state == ENG_IDLE) && ctrl.tx_full;
    assign ctrl.busy    = (state == ENG_BUSY);
    assign ctrl.rx_word = rx_sh;
    assign ctrl.rx_done = rx_done_q;
    assign run          = (state == ENG_BUSY);   // Baud counter runs only mid-word.

    assign tx_bit = lsb_q ? tx_sh[0] : tx_sh[DATA_W-1];
    assign mosi   = ss ? 1'b1 : tx_bit;          // Line idles high while deselected.
    // Deselected, sck follows the programmed CPOL so the slave sees the
    // right idle level before ss falls.
    assign sck    = ss ? ctrl.mode[1] : (mode_q[1] ^ hp[0]);

    // CPHA picks which half-period ends on the sampling edge.
    assign sample_now = tick && (hp[0] == mode_q[0]);
    // The first bit is loaded at take time, so the first and last
    // launch slots carry no shift.
    assign shift_now  = tick && (hp[0] != mode_q[0]) && (hp != '0) && (hp != HP_LAST);
    assign word_end   = tick && (hp == HP_LAST);

    ////////////////////////////////////////
    // Transfer FSM.
    ////////////////////////////////////////
    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            state     <= ENG_IDLE;
            hp        <= '0;
            mode_q    <= '0;
            lsb_q     <= 1'b0;
            ss        <= 1'b1;
            rx_done_q <= 1'b0;
        end else begin
            rx_done_q <= 1'b0;                   // Single-cycle pulse.
            case (state)
                ENG_IDLE: begin
                    if (ctrl.tx_full) begin
                        state  <= ENG_BUSY;
                        hp     <= '0;
                        mode_q <= ctrl.mode;     // Later CTRL writes wait for the next word.
                        lsb_q  <= ctrl.lsbfirst;
                        ss     <= 1'b0;
                    end
                end
                ENG_BUSY: begin
                    if (tick) begin
                        hp <= hp + 1'b1;
                    end
                    if (word_end) begin
                        state     <= ENG_IDLE;
                        hp        <= '0;
                        rx_done_q <= 1'b1;       // rx_sh holds the full word next cycle.
                        ss        <= !ctrl.tx_full;  // Stay selected if another word waits.
                    end
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

    // Shift registers.
    always_ff @(posedge wr) begin
        if (ctrl.tx_take) begin
            tx_sh <= ctrl.tx_word;
        end else if (shift_now) begin
            if (lsb_q) begin
                tx_sh <= {1'b1, tx_sh[DATA_W-1:1]};
            end else begin
                tx_sh <= {tx_sh[DATA_W-2:0], 1'b1};
            end
        end
        if (sample_now) begin
            if (lsb_q) begin
                rx_sh <= {miso, rx_sh[DATA_W-1:1]};  // First bit ends up in bit 0.
            end else begin
                rx_sh <= {rx_sh[DATA_W-2:0], miso};
            end
        end
    end

    a_ss_low_busy: assert property (@(posedge wr) disable iff (rst)
        (state == ENG_BUSY) |-> !ss);

    // A take needs a full buffer, and the register block empties it next edge.
    a_take_full: assert property (@(posedge wr) disable iff (rst)
        ctrl.tx_take |-> ctrl.tx_full ##1 !ctrl.tx_full);

endmodule

//--- logic/spi_master_top.sv
`timescale 1ns/1ns
/* SPI master top level with plain APB and SPI pins. */
module spi_master_top #(
    parameter int PRESC_W = 8                // Width of the baud prescaler counter.
) (
    input  logic               wr,
    input  logic               rst,
    // APB slave.
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  spi_pkg::apb_addr_t paddr,
    input  spi_pkg::apb_data_t pwdata,
    output spi_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr,
    // SPI pins.
    output logic               sck,
    output logic               mosi,
    input  logic               miso,
    output logic               ss
);

    logic run;                               // Engine is mid-word.
    logic tick;                              // End of an sck half-period.

    spi_ctrl_if ctrl_bus ();

    // Host side.
    spi_apb_regs u_regs (
        .wr      (wr),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .ctrl    (ctrl_bus.regs)
    );

    // Line side.
    spi_engine u_engine (
        .wr   (wr),
        .rst  (rst),
        .ctrl (ctrl_bus.engine),
        .run  (run),
        .tick (tick),
        .sck  (sck),
        .mosi (mosi),
        .miso (miso),
        .ss   (ss)
    );

    spi_baud_gen #(
        .PRESC_W (PRESC_W)
    ) u_baud (
        .wr    (wr),
        .rst   (rst),
        .run   (run),
        .presc (ctrl_bus.presc),
        .tick  (tick)
    );

endmodule

//--- verif/tb_spi_master.sv
`timescale 1ns/1ns
/* SPI master testbench with APB tasks, MISO loopback, line monitor,
   concurrent checks, test sequence, timeout and summary. */
module tb_spi_master;
    import spi_pkg::*;

    localparam int N_WORDS     = 15;                 // Words sent over all tests.
    localparam int N_TESTS     = 6;                  // Tests in the sequence.
    localparam int TIMEOUT_CYC = N_WORDS * 2 * DATA_W * 256 + 2000;

    logic      wr, rst, psel, penable, pwrite, pready, pslverr, sck, mosi, ss;
    apb_addr_t paddr;
    apb_data_t pwdata, prdata, st;
    spi_mode_t cur_mode = '0;                        // Last mode written to CTRL.
    logic      cur_lsb  = 1'b0;
    logic      exp_slverr = 1'b0;                    // pslverr expected in each access cycle.
    logic      prev_sck, prev_ss, prev_mosi, exp_bit;
    bit        check_half = 1'b0;                    // Measure sck half-periods.
    int        seed = 71;
    int        cycles = 0, seq_errs = 0, mon_errs = 0, sck_errs = 0, mosi_errs = 0;
    int        edges = 0, ss_rises = 0, words_sent = 0, bit_idx = 0, half_len = 0;
    int        exp_half = 0, err_mark = 0, edge_mark = 0, rise_mark = 0;
    int        tests = 0, failed = 0;
    int        presc_list[3] = '{0, 3, 7};
    string     cur_test = "reset";
    word_t     exp_q[$];                             // Accepted words in transmit order.
    word_t     w1, w2;

    // MISO loops back to MOSI, so every mode must return the sent word.
    spi_master_top #(.PRESC_W(8)) DUT (.*, .miso(mosi));

    initial begin
        wr = 1'b0;
        forever #5 wr = ~wr;
    end

    always @(posedge wr) begin
        cycles++;
        if (cycles >= TIMEOUT_CYC) begin
            $display("Timeout: run stopped after %0d cycles in test %s", cycles, cur_test);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic int compare(string what, apb_data_t exp, apb_data_t act);
        assert (exp == act) else
            $display("Mismatch in %s: %s expected 0x%0h, actual 0x%0h",
                     cur_test, what, exp, act);
        return (exp == act) ? 0 : 1;
    endfunction

    function automatic int total_errs();
        return seq_errs + mon_errs + sck_errs + mosi_errs;
    endfunction

    ////////////////////////////////////////
    // Line monitor sampled mid-cycle.
    ////////////////////////////////////////
    always @(negedge wr) begin
        if (!rst) begin
            if (!prev_ss && sck != prev_sck) begin
                // Sampling edge rises when CPOL equals CPHA.
                if (sck == (cur_mode[1] == cur_mode[0])) begin
                    edges++;
                    if (words_sent >= exp_q.size()) begin
                        $display("Error in %s: sampling edge with no word queued", cur_test);
                        mon_errs++;
                    end else begin
                        exp_bit = cur_lsb ? exp_q[words_sent][bit_idx]
                                          : exp_q[words_sent][DATA_W-1-bit_idx];
                        mon_errs += compare("mosi bit", apb_data_t'(exp_bit),
                                            apb_data_t'(prev_mosi));
                        bit_idx++;
                        if (bit_idx == DATA_W) begin
                            bit_idx = 0;
                            words_sent++;
                        end
                    end
                end
                if (check_half) mon_errs += compare("half-period", exp_half, half_len);
                half_len = 1;
            end else begin
                half_len = (prev_ss && !ss) ? 1 : half_len + 1;   // ss falling opens half-period 0.
            end
            if (!prev_ss && ss) ss_rises++;
        end
        prev_sck  = sck;
        prev_ss   = ss;
        prev_mosi = mosi;
    end

    // A deselected line holds sck at the programmed CPOL and mosi high.
    a_idle_sck: assert property (@(negedge wr) disable iff (rst) ss |-> sck == cur_mode[1])
        else begin
            $display("Mismatch in %s: idle sck expected %0b, actual %0b",
                     cur_test, cur_mode[1], sck);
            sck_errs++;
        end
    a_idle_mosi: assert property (@(negedge wr) disable iff (rst) ss |-> mosi)
        else begin
            $display("Mismatch in %s: idle mosi expected 1, actual %0b", cur_test, mosi);
            mosi_errs++;
        end

    ////////////////////////////////////////
    // APB and sequence helpers.
    ////////////////////////////////////////
    task apb_access(input logic write, input apb_addr_t addr, input apb_data_t data,
                    output apb_data_t rdata);
        @(posedge wr);
        #1;
        psel   = 1'b1;                               // Setup cycle.
        pwrite = write;
        paddr  = addr;
        pwdata = data;
        @(posedge wr);
        #1;
        penable = 1'b1;
        @(negedge wr);
        rdata = prdata;                              // Access cycle outputs are stable here.
        seq_errs += compare("pready", 1, apb_data_t'(pready));
        seq_errs += compare("pslverr", apb_data_t'(exp_slverr), apb_data_t'(pslverr));
        @(posedge wr);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task set_ctrl(input spi_mode_t mode, input logic lsb, input presc_t p);
        apb_access(1'b1, ADDR_CTRL, apb_data_t'({p, lsb, mode}), st);
        cur_mode = mode;
        cur_lsb  = lsb;
    endtask

    task send_word(input word_t w);
        exp_q.push_back(w);
        apb_access(1'b1, ADDR_TXDATA, apb_data_t'(w), st);
    endtask

    // Every queued word has left the line and char_received is up.
    task wait_done();
        while (words_sent < exp_q.size() || !ss) @(negedge wr);
        do begin
            apb_access(1'b0, ADDR_STATUS, '0, st);
        end while (!st[STAT_CHAR_RX]);
    endtask

    task check_rx(input word_t exp);
        apb_access(1'b0, ADDR_RXDATA, '0, st);
        seq_errs += compare("rxdata", apb_data_t'(exp), st);
    endtask

    task start_test(input string name);
        cur_test  = name;
        err_mark  = total_errs();
        edge_mark = edges;
        rise_mark = ss_rises;
    endtask

    task end_test();
        tests++;
        if (total_errs() > err_mark) failed++;
        $display("Test %-9s %s", cur_test, (total_errs() > err_mark) ? "FAILED" : "ok");
    endtask

    ////////////////////////////////////////
    // Test sequence.
    ////////////////////////////////////////
    initial begin
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (16) @(posedge wr);
        #1;
        rst = 1'b0;

        start_test("reset");
        seq_errs += compare("ss", 1, apb_data_t'(ss));
        seq_errs += compare("mosi", 1, apb_data_t'(mosi));
        seq_errs += compare("sck", 0, apb_data_t'(sck));
        apb_access(1'b0, ADDR_STATUS, '0, st);
        seq_errs += compare("status", 32'h1, st);   // Only tx_empty is set.
        end_test();

        // All four modes in both bit orders with the idle and mosi checks running.
        start_test("loopback");
        for (int m = 0; m < 4; m++) begin
            for (int l = 0; l < 2; l++) begin
                set_ctrl(spi_mode_t'(m), l[0], presc_t'(0));
                edge_mark = edges;
                rise_mark = ss_rises;
                w1 = word_t'($random(seed));
                send_word(w1);
                wait_done();
                check_rx(w1);
                apb_access(1'b0, ADDR_STATUS, '0, st);
                seq_errs += compare("char_received after read", 0,
                                    apb_data_t'(st[STAT_CHAR_RX]));
                seq_errs += compare("sampling edges", DATA_W, edges - edge_mark);
                seq_errs += compare("ss rises", 1, ss_rises - rise_mark);
            end
        end
        end_test();

        start_test("b2b");
        set_ctrl(spi_mode_t'(2), 1'b0, presc_t'(1));
        w1 = word_t'($random(seed));
        w2 = word_t'($random(seed));
        send_word(w1);
        send_word(w2);                              // Lands while w1 is shifting.
        wait_done();
        check_rx(w2);
        seq_errs += compare("ss rises", 1, ss_rises - rise_mark);
        seq_errs += compare("sampling edges", 2 * DATA_W, edges - edge_mark);
        end_test();

        start_test("overflow");
        set_ctrl(spi_mode_t'(1), 1'b1, presc_t'(0));
        w1 = word_t'($random(seed));
        w2 = word_t'($random(seed));
        send_word(w1);
        send_word(w2);
        apb_access(1'b1, ADDR_TXDATA, apb_data_t'(~w2), st);   // Buffer full, must be dropped.
        apb_access(1'b0, ADDR_STATUS, '0, st);
        seq_errs += compare("send_error", 1, apb_data_t'(st[STAT_SEND_ERR]));
        wait_done();
        check_rx(w2);
        apb_access(1'b1, ADDR_STATUS, 32'h8, st);
        apb_access(1'b0, ADDR_STATUS, '0, st);
        seq_errs += compare("status after clear", 32'h1, st);
        end_test();

        start_test("prescale");
        for (int i = 0; i < 3; i++) begin
            set_ctrl(spi_mode_t'(0), 1'b0, presc_t'(presc_list[i]));
            exp_half   = 2 << presc_list[i];        // 2^(p+1) cycles.
            check_half = 1'b1;
            w1 = word_t'($random(seed));
            send_word(w1);
            wait_done();
            check_half = 1'b0;
            check_rx(w1);
        end
        end_test();

        // Bad accesses raise pslverr and leave the registers alone.
        start_test("apb_err");
        exp_slverr = 1'b1;
        apb_access(1'b0, 4'h2, '0, st);             // Unmapped offset.
        apb_access(1'b1, ADDR_RXDATA, apb_data_t'(~w1), st);
        exp_slverr = 1'b0;
        check_rx(w1);                               // RXDATA still holds the last word.
        apb_access(1'b0, ADDR_STATUS, '0, st);
        seq_errs += compare("status", 32'h1, st);
        end_test();

        $display("Summary: %0d of %0d tests run, %0d failed, %0d errors",
                 tests, N_TESTS, failed, total_errs());
        if (tests == N_TESTS && failed == 0 && total_errs() == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- list.f
logic/spi_pkg.sv
logic/spi_ctrl_if.sv
logic/spi_apb_regs.sv
logic/spi_baud_gen.sv
logic/spi_engine.sv
logic/spi_master_top.sv
verif/tb_spi_master.sv

//--- run.sh
#!/bin/sh
# Build the SPI master testbench with Verilator, run it, then look for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_spi_master -f list.f -o tb_sim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log
grep -qx ">>> PASS" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
